// File: hw/sad_pkg.sv
/*
 * shared definitions for the SAD engine
 *  - block geometry and datapath width localparams
 *  - pixel, row, row sum, block SAD and candidate index types
 */

package sad_pkg;

  // --------------------------------------------------
  // block geometry
  // --------------------------------------------------
  localparam int PIX_W    = 8;  // unsigned pixel
  localparam int ROW_PIX  = 8;  // pixels per row
  localparam int BLK_ROWS = 8;  // rows per block

  // adder tree depth, log2 of the row length
  localparam int TREE_STAGES = $clog2(ROW_PIX);

  // --------------------------------------------------
  // datapath widths
  // --------------------------------------------------
  localparam int ROW_SUM_W = PIX_W + TREE_STAGES;  // 8 x 255 = 2040 fits in 11 bits
  localparam int BLK_SAD_W = 14;                   // 64 x 255 = 16320
  localparam int CAND_W    = 4;                    // up to 16 candidates per set

  // --------------------------------------------------
  // types
  // --------------------------------------------------
  typedef logic [PIX_W-1:0] pixel_t;

  // one pixel row, also reused for the abs diff vector
  typedef pixel_t [ROW_PIX-1:0] row_t;

  typedef logic [ROW_SUM_W-1:0] row_sum_t;
  typedef logic [BLK_SAD_W-1:0] blk_sad_t;
  typedef logic [CAND_W-1:0]    cand_t;

endpackage

// File: hw/pixel_row_if.sv
/*
 * pixel_row_if
 *  one current/reference row pair with its strobe
 *  and the block / search set framing flags
 */

`timescale 1ns/1ps

interface pixel_row_if;

  logic          valid;      // one cycle per row pair
  sad_pkg::row_t cur_row;    // current block row
  sad_pkg::row_t ref_row;    // candidate block row
  logic          first_row;  // row 0 of a block
  logic          last_row;   // row 7 of a block
  logic          last_cand;  // row of the final candidate in the set

  // driven from the top level ports
  modport source (
    output valid, cur_row, ref_row, first_row, last_row, last_cand
  );

  // consumed by the abs diff stage
  modport sink (
    input valid, cur_row, ref_row, first_row, last_row, last_cand
  );

endinterface

// File: hw/row_absdiff.sv
/*
 * row_absdiff
 *  per-lane |cur - ref| for one row pair, registered
 *  framing flags registered alongside as the row tag
 */

`timescale 1ns/1ps

module row_absdiff (
  input  logic          clk,
  input  logic          nrst,
  pixel_row_if.sink     row,
  output sad_pkg::row_t diff,
  output logic          tag_valid,
  output logic          tag_first,
  output logic          tag_last,
  output logic          tag_cand_last
);

  sad_pkg::row_t abs_d;  // combinational magnitudes

  // unsigned magnitude, no sign bit needed
  always_comb begin
    for (int i = 0; i < sad_pkg::ROW_PIX; i++) begin
      if (row.cur_row[i] >= row.ref_row[i]) begin
        abs_d[i] = row.cur_row[i] - row.ref_row[i];
      end else begin
        abs_d[i] = row.ref_row[i] - row.cur_row[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (row.valid) diff <= abs_d;  // hold otherwise, less toggling
  end

  // tag follows the row into the tree
  always_ff @(posedge clk) begin
    if (!nrst) begin
      tag_valid     <= 1'b0;
      tag_first     <= 1'b0;
      tag_last      <= 1'b0;
      tag_cand_last <= 1'b0;
    end else begin
      tag_valid     <= row.valid;
      tag_first     <= row.first_row;  // only meaningful with tag_valid
      tag_last      <= row.last_row;
      tag_cand_last <= row.last_cand;
    end
  end

endmodule

// File: hw/adder_tree.sv
/*
 * adder_tree
 *  pipelined binary tree, one register level per stage
 *  inputs zero padded up to a power of two
 *  latency equals the stage count
 */

`timescale 1ns/1ps

module adder_tree #(
  parameter int INPUTS_NUM  = 8,
  parameter int IDATA_WIDTH = 8
) (
  input  logic                                        clk,
  input  logic                                        nrst,
  input  logic [INPUTS_NUM-1:0][IDATA_WIDTH-1:0]      idata,
  output logic [IDATA_WIDTH+$clog2(INPUTS_NUM)-1:0]   odata
);

  localparam int STAGES = $clog2(INPUTS_NUM);
  localparam int PAD    = 2 ** STAGES;           // padded input count
  localparam int ODW    = IDATA_WIDTH + STAGES;  // full result width

  // heap layout, node 0 is the root
  // children of node k are 2k+1 and 2k+2, leaves at PAD-1 .. 2*PAD-2
  logic [2*PAD-2:0][ODW-1:0] node;

  // --------------------------------------------------
  // leaves
  // --------------------------------------------------
  for (genvar i = 0; i < PAD; i++) begin : g_leaf
    if (i < INPUTS_NUM) begin : g_in
      assign node[PAD-1+i] = ODW'(idata[i]);  // zero extend
    end else begin : g_pad
      assign node[PAD-1+i] = '0;              // padding lane
    end
  end

  // --------------------------------------------------
  // adder levels
  // --------------------------------------------------
  for (genvar k = 0; k < PAD - 1; k++) begin : g_node
    // depth from root, then the stage this node belongs to
    localparam int LVL = $clog2(k + 2) - 1;
    localparam int ST  = STAGES - LVL;
    localparam int W   = IDATA_WIDTH + ST;  // grows one bit per stage

    logic [W-1:0] sum;

    // child outputs only carry W-1 live bits
    assign sum = {1'b0, node[2*k+1][W-2:0]} + {1'b0, node[2*k+2][W-2:0]};

    always_ff @(posedge clk) begin
      if (!nrst) begin
        node[k] <= '0;
      end else begin
        node[k] <= ODW'(sum);  // upper bits stay zero
      end
    end
  end

  // single input degenerates to a wire from the leaf
  assign odata = node[0];

endmodule

// File: hw/block_accum.sv
/*
 * block_accum
 *  flag delay line matched to the adder tree depth
 *  row sum accumulator, one-cycle strobe per finished block
 */

`timescale 1ns/1ps

module block_accum (
  input  logic               clk,
  input  logic               nrst,
  input  logic               tag_valid,
  input  logic               tag_first,
  input  logic               tag_last,
  input  logic               tag_cand_last,
  input  sad_pkg::row_sum_t  row_sum,
  output logic               blk_valid,
  output logic               blk_cand_last,
  output sad_pkg::blk_sad_t  blk_sad
);

  // --------------------------------------------------
  // flag delay, TREE_STAGES deep
  // --------------------------------------------------
  logic [sad_pkg::TREE_STAGES-1:0] dly_valid;
  logic [sad_pkg::TREE_STAGES-1:0] dly_first;
  logic [sad_pkg::TREE_STAGES-1:0] dly_last;
  logic [sad_pkg::TREE_STAGES-1:0] dly_cand;

  sad_pkg::blk_sad_t acc;  // running block sum

  always_ff @(posedge clk) begin
    if (!nrst) begin
      dly_valid <= '0;
      dly_first <= '0;
      dly_last  <= '0;
      dly_cand  <= '0;
    end else begin
      dly_valid <= {dly_valid[sad_pkg::TREE_STAGES-2:0], tag_valid};
      dly_first <= {dly_first[sad_pkg::TREE_STAGES-2:0], tag_first};
      dly_last  <= {dly_last[sad_pkg::TREE_STAGES-2:0], tag_last};
      dly_cand  <= {dly_cand[sad_pkg::TREE_STAGES-2:0], tag_cand_last};
    end
  end

  // --------------------------------------------------
  // accumulate, top of delay line lines up with row_sum
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!nrst) begin
      acc           <= '0;
      blk_valid     <= 1'b0;
      blk_cand_last <= 1'b0;
    end else begin
      blk_valid     <= dly_valid[sad_pkg::TREE_STAGES-1] & dly_last[sad_pkg::TREE_STAGES-1];
      blk_cand_last <= dly_cand[sad_pkg::TREE_STAGES-1] & dly_last[sad_pkg::TREE_STAGES-1];
      if (dly_valid[sad_pkg::TREE_STAGES-1]) begin
        if (dly_first[sad_pkg::TREE_STAGES-1]) begin
          acc <= sad_pkg::blk_sad_t'(row_sum);        // new block, drop old sum
        end else begin
          acc <= acc + sad_pkg::blk_sad_t'(row_sum);
        end
      end
    end
  end

  assign blk_sad = acc;  // complete only with blk_valid

endmodule

// File: hw/best_match.sv
/*
 * best_match
 *  candidate counter within a search set
 *  running minimum block SAD and its index, one-cycle result strobe
 */

`timescale 1ns/1ps

module best_match (
  input  logic              clk,
  input  logic              nrst,
  input  logic              blk_valid,
  input  logic              blk_cand_last,
  input  sad_pkg::blk_sad_t blk_sad,
  output logic              best_valid,
  output sad_pkg::blk_sad_t best_sad,
  output sad_pkg::cand_t    best_cand
);

  sad_pkg::cand_t cnt;   // index of the incoming block
  logic           take;  // incoming block becomes the best

  // first block always wins, later ones only if strictly smaller
  // so a tie keeps the earlier index
  assign take = (cnt == '0) || (blk_sad < best_sad);

  always_ff @(posedge clk) begin
    if (!nrst) begin
      cnt        <= '0;
      best_valid <= 1'b0;
      best_sad   <= '0;
      best_cand  <= '0;
    end else begin
      best_valid <= blk_valid & blk_cand_last;  // result goes out with the last block
      if (blk_valid) begin
        if (take) begin
          best_sad  <= blk_sad;
          best_cand <= cnt;
        end
        // restart numbering for the next set
        if (blk_cand_last) begin
          cnt <= '0;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

endmodule

// File: hw/sad_engine.sv
/*
 * sad_engine, top level
 *  row ports -> abs diff -> adder tree -> block accumulator -> best match
 */

`timescale 1ns/1ps

module sad_engine (
  input  logic              clk,
  input  logic              nrst,
  input  logic              row_valid,
  input  logic              row_first,
  input  logic              row_last,
  input  logic              cand_last,
  input  sad_pkg::row_t     cur_row,
  input  sad_pkg::row_t     ref_row,
  output logic              sad_valid,
  output sad_pkg::blk_sad_t sad,
  output logic              best_valid,
  output sad_pkg::blk_sad_t best_sad,
  output sad_pkg::cand_t    best_cand
);

  // --------------------------------------------------
  // row input bundle
  // --------------------------------------------------
  pixel_row_if row_if ();

  assign row_if.valid     = row_valid;
  assign row_if.cur_row   = cur_row;
  assign row_if.ref_row   = ref_row;
  assign row_if.first_row = row_first;
  assign row_if.last_row  = row_last;
  assign row_if.last_cand = cand_last;

  sad_pkg::row_t     diff;
  sad_pkg::row_sum_t row_sum;
  logic tag_valid, tag_first, tag_last, tag_cand_last;
  logic blk_cand_last;

  // edge n
  row_absdiff row_absdiff_i (
    .clk           (clk),
    .nrst          (nrst),
    .row           (row_if.sink),
    .diff          (diff),
    .tag_valid     (tag_valid),
    .tag_first     (tag_first),
    .tag_last      (tag_last),
    .tag_cand_last (tag_cand_last)
  );

  // edges n+1 .. n+3
  adder_tree #(
    .INPUTS_NUM  (sad_pkg::ROW_PIX),
    .IDATA_WIDTH (sad_pkg::PIX_W)
  ) adder_tree_i (
    .clk   (clk),
    .nrst  (nrst),
    .idata (diff),
    .odata (row_sum)
  );

  // edge n+4, block SAD goes straight out
  block_accum block_accum_i (
    .clk           (clk),
    .nrst          (nrst),
    .tag_valid     (tag_valid),
    .tag_first     (tag_first),
    .tag_last      (tag_last),
    .tag_cand_last (tag_cand_last),
    .row_sum       (row_sum),
    .blk_valid     (sad_valid),
    .blk_cand_last (blk_cand_last),
    .blk_sad       (sad)
  );

  // edge n+5
  best_match best_match_i (
    .clk           (clk),
    .nrst          (nrst),
    .blk_valid     (sad_valid),
    .blk_cand_last (blk_cand_last),
    .blk_sad       (sad),
    .best_valid    (best_valid),
    .best_sad      (best_sad),
    .best_cand     (best_cand)
  );

endmodule

// File: verification/sad_engine_tb.sv
/*
 * testbench for the SAD engine
 *  table of search sets, rows generated with a fixed seed
 *  reference SAD model, queued expectations with strobe cycles
 *  compare tasks, cycle-count timeout
 */

`timescale 1ns/1ps

module sad_engine_tb;

  localparam int N_SETS    = 8;
  localparam int K_EQUAL   = 0;  // ref block equals cur block
  localparam int K_EXTREME = 1;  // cur all 0, ref all 255
  localparam int K_RANDOM  = 2;
  localparam int K_TIE     = 3;  // candidates 1 and last share the minimum

  typedef struct packed {
    int ncand;  // candidates in the set
    int kind;
    int gap;    // idle cycles after each row
    int cut;    // rows of the last candidate before a reset, 0 = whole set
  } set_t;

  logic clk, nrst;
  logic row_valid, row_first, row_last, cand_last;
  sad_pkg::row_t cur_row, ref_row;
  logic sad_valid, best_valid;
  sad_pkg::blk_sad_t sad, best_sad;
  sad_pkg::cand_t best_cand;

  set_t tbl [N_SETS];
  string kind_name [4] = '{"equal", "extreme", "random", "tie"};
  sad_pkg::row_t cur_blk [sad_pkg::BLK_ROWS];
  sad_pkg::row_t ref_blk [sad_pkg::BLK_ROWS];

  // expectations, values plus the cycle count at the strobe
  sad_pkg::blk_sad_t exp_sad_q[$];
  int                exp_sad_cyc_q[$];
  sad_pkg::blk_sad_t exp_best_q[$];
  sad_pkg::cand_t    exp_cand_q[$];
  int                exp_best_cyc_q[$];

  integer seed;
  int cyc = 0;     // rising edges so far
  int limit = 0;
  int last_cyc;    // cyc as read when the last row was driven
  int errors = 0;
  int checks = 0;

  sad_engine sad_engine_i (
    .clk (clk), .nrst (nrst), .row_valid (row_valid), .row_first (row_first),
    .row_last (row_last), .cand_last (cand_last), .cur_row (cur_row), .ref_row (ref_row),
    .sad_valid (sad_valid), .sad (sad), .best_valid (best_valid),
    .best_sad (best_sad), .best_cand (best_cand)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------
  // reference model and compare tasks
  // --------------------------------------------------
  function automatic int block_sad(input sad_pkg::row_t c [sad_pkg::BLK_ROWS],
                                   input sad_pkg::row_t r [sad_pkg::BLK_ROWS]);
    int sum;
    sum = 0;
    for (int i = 0; i < sad_pkg::BLK_ROWS; i++) begin
      for (int p = 0; p < sad_pkg::ROW_PIX; p++) begin
        if (c[i][p] > r[i][p]) sum += int'(c[i][p]) - int'(r[i][p]);
        else                   sum += int'(r[i][p]) - int'(c[i][p]);
      end
    end
    return sum;
  endfunction

  function automatic sad_pkg::pixel_t rnd_pix();
    return sad_pkg::pixel_t'($random(seed));
  endfunction

  task automatic compare_sad(input sad_pkg::blk_sad_t exp, input sad_pkg::blk_sad_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %0t sad expected %0d got %0d", $time, exp, act);
    end
  endtask

  task automatic compare_best(input sad_pkg::blk_sad_t exp_s, input sad_pkg::blk_sad_t act_s,
                              input sad_pkg::cand_t exp_c, input sad_pkg::cand_t act_c);
    checks++;
    if (act_s !== exp_s || act_c !== exp_c) begin
      errors++;
      if (act_s !== exp_s) begin
        $display("MISMATCH %0t best_sad expected %0d got %0d", $time, exp_s, act_s);
      end
      if (act_c !== exp_c) begin
        $display("MISMATCH %0t best_cand expected %0d got %0d", $time, exp_c, act_c);
      end
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("MISMATCH %0t %s cycle expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  // --------------------------------------------------
  // drivers
  // --------------------------------------------------
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      row_valid <= 1'b0;
    end
  endtask

  task automatic reset_dut();
    @(posedge clk);
    nrst      <= 1'b0;
    row_valid <= 1'b0;
    repeat (3) @(posedge clk);
    nrst <= 1'b1;
  endtask

  task automatic send_row(input sad_pkg::row_t c, input sad_pkg::row_t r,
                          input logic first, input logic last, input logic cl, input int gap);
    @(posedge clk);
    last_cyc  = cyc;  // pre-update value, DUT samples this row one edge later
    row_valid <= 1'b1;
    row_first <= first;
    row_last  <= last;
    cand_last <= cl;
    cur_row   <= c;
    ref_row   <= r;
    idle(gap);
  endtask

  // timeout, the counter also times the strobes
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (limit > 0 && cyc >= limit) begin
      $display("ERROR: timeout, results still missing after %0d cycles", cyc);
      $display("tests failed");
      $finish;
    end
  end

  // monitor, outputs sampled mid cycle
  always @(negedge clk) begin
    if (!nrst && (sad_valid || best_valid)) begin
      errors++;
      $display("ERROR: strobe high during reset at %0t", $time);
    end
    if (sad_valid) begin
      if (exp_sad_q.size() == 0) begin
        errors++;
        $display("ERROR: sad_valid at %0t with no block expected", $time);
      end else begin
        compare_sad(exp_sad_q.pop_front(), sad);
        check_latency("sad_valid", exp_sad_cyc_q.pop_front(), cyc);
      end
    end
    if (best_valid) begin
      if (exp_best_q.size() == 0) begin
        errors++;
        $display("ERROR: best_valid at %0t with no search result expected", $time);
      end else begin
        compare_best(exp_best_q.pop_front(), best_sad, exp_cand_q.pop_front(), best_cand);
        check_latency("best_valid", exp_best_cyc_q.pop_front(), cyc);
      end
    end
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    int rows;
    int err0;
    int nrows;
    int blk;
    int best_s;
    int best_c;
    int cand_sad [2**sad_pkg::CAND_W];
    logic tie;
    logic interrupted;
    seed      = 32'h72c5;
    nrst      = 1'b0;
    row_valid = 1'b0;
    row_first = 1'b0;
    row_last  = 1'b0;
    cand_last = 1'b0;
    cur_row   = '0;
    ref_row   = '0;
    // ncand, kind, gap, cut
    tbl = '{'{2, K_EQUAL, 0, 0}, '{1, K_EXTREME, 1, 0}, '{4, K_RANDOM, 0, 0},
            '{3, K_RANDOM, 2, 0}, '{5, K_TIE, 1, 0}, '{3, K_RANDOM, 0, 8},
            '{16, K_TIE, 0, 0}, '{16, K_RANDOM, 2, 0}};
    rows = 0;
    foreach (tbl[i]) rows += tbl[i].ncand * sad_pkg::BLK_ROWS;
    limit = rows * 3 + 20 * N_SETS;  // at most 3 cycles per row
    reset_dut();

    for (int s = 0; s < N_SETS; s++) begin
      err0 = errors;
      for (int r = 0; r < sad_pkg::BLK_ROWS; r++) begin
        for (int p = 0; p < sad_pkg::ROW_PIX; p++) begin
          cur_blk[r][p] = (tbl[s].kind == K_EXTREME) ? 8'h00 : rnd_pix();
        end
      end
      for (int c = 0; c < tbl[s].ncand; c++) begin
        tie = (tbl[s].kind == K_TIE) && (c == 1 || c == tbl[s].ncand - 1);
        for (int r = 0; r < sad_pkg::BLK_ROWS; r++) begin
          for (int p = 0; p < sad_pkg::ROW_PIX; p++) begin
            case (tbl[s].kind)
              K_EQUAL:   ref_blk[r][p] = cur_blk[r][p];
              K_EXTREME: ref_blk[r][p] = 8'hff;
              default:   ref_blk[r][p] = tie ? (cur_blk[r][p] ^ 8'h01) : rnd_pix();
            endcase
          end
        end
        blk         = block_sad(cur_blk, ref_blk);
        cand_sad[c] = blk;
        interrupted = (tbl[s].cut > 0) && (c == tbl[s].ncand - 1);
        nrows       = interrupted ? tbl[s].cut : sad_pkg::BLK_ROWS;
        for (int r = 0; r < nrows; r++) begin
          send_row(cur_blk[r], ref_blk[r], r == 0, r == sad_pkg::BLK_ROWS - 1,
                   c == tbl[s].ncand - 1, tbl[s].gap);
        end
        if (!interrupted) begin
          exp_sad_q.push_back(sad_pkg::blk_sad_t'(blk));
          exp_sad_cyc_q.push_back(last_cyc + 6);  // edge n+4
          if (c == tbl[s].ncand - 1) begin
            // smallest SAD of the set, then the first candidate that reaches it
            best_s = cand_sad[0];
            for (int k = 1; k <= c; k++) begin
              if (cand_sad[k] < best_s) best_s = cand_sad[k];
            end
            best_c = 0;
            while (cand_sad[best_c] != best_s) best_c++;
            exp_best_q.push_back(sad_pkg::blk_sad_t'(best_s));
            exp_cand_q.push_back(sad_pkg::cand_t'(best_c));
            exp_best_cyc_q.push_back(last_cyc + 7);  // edge n+5
          end
        end
      end
      if (tbl[s].cut > 0) reset_dut();  // last block still in the pipeline, dropped
      idle(1);
      while (exp_sad_q.size() > 0 || exp_best_q.size() > 0) @(negedge clk);
      $display("set %0d: %0d candidates, %s, gap %0d, cut %0d: %s", s, tbl[s].ncand,
               kind_name[tbl[s].kind], tbl[s].gap, tbl[s].cut,
               (errors == err0) ? "ok" : "FAILED");
    end

    repeat (8) @(posedge clk);  // room for stray strobes
    if (exp_sad_q.size() > 0 || exp_best_q.size() > 0) begin
      errors++;
      $display("ERROR: %0d block results and %0d search results never arrived",
               exp_sad_q.size(), exp_best_q.size());
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: src.f
hw/sad_pkg.sv
hw/pixel_row_if.sv
hw/row_absdiff.sv
hw/adder_tree.sv
hw/block_accum.sv
hw/best_match.sv
hw/sad_engine.sv
verification/sad_engine_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= sad_engine_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
